//--- acq_top.f
+incdir+include
verilog/acq_pkg.sv
verilog/acq_stream_if.sv
verilog/acq_mem_if.sv
verilog/acq_trigger.sv
verilog/acq_writer.sv
verilog/acq_reader.sv
verilog/acq_buffer.sv
verilog/acq_top.sv
bench/acq_tb.sv

//--- bench/acq_tb.sv
// directed testbench for the trace acquisition subsystem
// a reference model follows the acquisition rules and the sample buffer,
// each test task drives acq_top and checks its response against the model
`timescale 1ns/1ps

module acq_tb import acq_pkg::*;;

  // limit a few times the several hundred cycles the tests take
  localparam int MAX_CYC = 4000;

  //////////////////////////////
  // dut signals
  //////////////////////////////

  logic    sti;
  logic    ctl_rst;
  time_t   cts;
  logic    src_vld;
  sample_t src_dat;
  logic    src_lst;
  logic    src_rdy;
  trg_t    cfg_trg;
  logic    cfg_con;
  logic    cfg_aut;
  count_t  cfg_pre;
  count_t  cfg_pst;
  logic    ctl_acq;
  trg_t    ctl_trg;
  logic    ctl_stp;
  count_t  sts_pre;
  count_t  sts_pst;
  logic    sts_acq;
  logic    sts_trg;
  time_t   cts_acq;
  time_t   cts_trg;
  time_t   cts_stp;
  logic    irq_trg;
  logic    irq_stp;
  addr_t   sts_wpt;
  addr_t   sts_end;
  logic    rd_req;
  addr_t   rd_adr;
  logic    rd_vld;
  sample_t rd_dat;
  logic    rd_bsy;

  // bench state
  int      errors = 0;
  int      cyc = 0;
  int      n_trg = 0;
  int      n_stp = 0;
  integer  seed;
  logic    strm_done;

  // reference model state
  logic    m_acq;
  logic    m_arm;
  logic    m_trg;
  count_t  m_pre;
  count_t  m_pst;
  addr_t   m_ptr;
  addr_t   m_end;
  time_t   m_cts_acq;
  time_t   m_cts_trg;
  time_t   m_cts_stp;
  sample_t exp_mem [256];
  // per cycle model terms
  logic    s_xfr;
  logic    s_acc;
  logic    s_trg;
  logic    s_trn;
  logic    s_stp;

  // port names match one to one
  acq_top dut (.*);

  //////////////////////////////
  // clock, time, watchdog
  //////////////////////////////

  initial begin
    sti = 1'b0;
    forever #10 sti = ~sti;
  end

  // time stamp source ticks once per cycle
  always @(posedge sti) begin
    #1;
    cts = cts + 1'b1;
  end

  always @(posedge sti) begin
    cyc = cyc + 1;
    if (cyc >= MAX_CYC) begin
      $display("timeout: tests still running after %0d cycles", cyc);
      $display("errors: %0d", errors);
      $display("Something failed");
      $finish;
    end
  end

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input count_t exp, input count_t act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_time(input string name, input time_t exp, input time_t act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////

  // inputs settle 1 ns after the edge, so the low phase sees the whole cycle
  always @(negedge sti) begin
    if (ctl_rst) begin
      m_acq     = 1'b0;
      m_arm     = 1'b0;
      m_trg     = 1'b0;
      m_pre     = '0;
      m_pst     = '0;
      m_ptr     = '0;
      m_end     = '0;
      m_cts_acq = '0;
      m_cts_trg = '0;
      m_cts_stp = '0;
    end else begin
      s_xfr = src_vld & src_rdy;
      s_acc = m_acq & s_xfr;
      // masked source fires only once armed
      s_trg = m_acq & m_arm & ~m_trg & (|(ctl_trg & cfg_trg));
      s_trn = m_trg | s_trg;
      s_stp = m_acq & (ctl_stp | (s_xfr & src_lst) |
                       (s_acc & s_trn & ~cfg_con & (m_pst + 1'b1 == cfg_pst)));
      check_bit("irq_trg pulse", s_trg, irq_trg);
      check_bit("irq_stp pulse", s_stp, irq_stp);
      if (irq_trg) n_trg++;
      if (irq_stp) n_stp++;
      // expected buffer write at the model pointer
      if (s_acc) begin
        exp_mem[m_ptr] = src_dat;
        if (src_lst | s_stp) begin
          m_end = m_ptr;
        end
        m_ptr = m_ptr + 1'b1;
      end
      // pre beats arm the trigger and post beats count toward the stop
      if (s_acc & s_trn) begin
        m_pst = m_pst + 1'b1;
      end
      if (s_acc & ~s_trn) begin
        if (m_pre + 1'b1 == cfg_pre) m_arm = 1'b1;
        m_pre = m_pre + 1'b1;
      end
      if (s_trg) begin
        m_trg     = 1'b1;
        m_cts_trg = cts;
      end
      // stop beats a start in the same cycle
      if (s_stp) begin
        m_acq     = 1'b0;
        m_cts_stp = cts;
      end else if (ctl_acq) begin
        m_acq     = 1'b1;
        m_trg     = cfg_aut;
        m_arm     = (cfg_pre == '0);
        m_pre     = '0;
        m_pst     = '0;
        m_cts_acq = cts;
      end
      if (ctl_acq) begin
        m_ptr = '0;
        m_end = '0;
      end
    end
  end

  //////////////////////////////
  // drive helpers
  //////////////////////////////

  // all of these start and end 1 ns after a rising edge
  task automatic idle(input int n);
    repeat (n) begin
      @(posedge sti);
      #1;
    end
  endtask

  task automatic pulse_acq();
    ctl_acq = 1'b1;
    @(posedge sti);
    #1;
    ctl_acq = 1'b0;
  endtask

  // returns the time stamp of the stop cycle
  task automatic pulse_stp(output time_t t);
    ctl_stp = 1'b1;
    @(negedge sti);
    t = cts;
    @(posedge sti);
    #1;
    ctl_stp = 1'b0;
  endtask

  task automatic fire_trigger(input string name, input trg_t v, input logic hit,
                              output time_t t);
    ctl_trg = v;
    @(negedge sti);
    check_bit({name, " irq_trg"}, hit, irq_trg);
    t = cts;
    @(posedge sti);
    #1;
    ctl_trg = '0;
  endtask

  // hold the beat until src_rdy takes it
  task automatic send_beat(input sample_t d, input logic lst);
    src_vld = 1'b1;
    src_dat = d;
    src_lst = lst;
    @(negedge sti);
    while (!src_rdy) @(negedge sti);
    @(posedge sti);
    #1;
    src_vld = 1'b0;
    src_lst = 1'b0;
  endtask

  // one host read where dbl keeps rd_req up for a second refused try
  task automatic read_check(input string name, input addr_t a, input sample_t expv,
                            input bit dbl);
    logic got;
    rd_req = 1'b1;
    rd_adr = a;
    @(posedge sti);
    #1;
    rd_req = dbl;
    rd_adr = a + 1'b1;
    @(negedge sti);
    if (dbl) check_bit({name, " rd_bsy"}, 1'b1, rd_bsy);
    got = rd_vld;
    if (got) check_sample(name, expv, rd_dat);
    @(posedge sti);
    #1;
    rd_req = 1'b0;
    @(negedge sti);
    if (rd_vld) begin
      if (got) begin
        report_failure({name, ": read data returned twice"});
      end else begin
        got = 1'b1;
        check_sample(name, expv, rd_dat);
      end
    end
    if (!got) report_failure({name, ": no read data within 2 cycles"});
    // refused request must not come back
    if (dbl) begin
      repeat (3) begin
        @(negedge sti);
        if (rd_vld) report_failure({name, ": refused read returned data"});
      end
    end
    @(posedge sti);
    #1;
  endtask

  // every status output against the model
  task automatic check_state(input string name);
    check_bit({name, " sts_acq"}, m_acq, sts_acq);
    check_bit({name, " sts_trg"}, m_trg, sts_trg);
    check_count({name, " sts_pre"}, m_pre, sts_pre);
    check_count({name, " sts_pst"}, m_pst, sts_pst);
    check_time({name, " cts_acq"}, m_cts_acq, cts_acq);
    check_time({name, " cts_trg"}, m_cts_trg, cts_trg);
    check_time({name, " cts_stp"}, m_cts_stp, cts_stp);
    check_addr({name, " sts_wpt"}, m_ptr, sts_wpt);
    check_addr({name, " sts_end"}, m_end, sts_end);
  endtask

  task automatic set_mode(input logic aut, input logic con, input count_t pre,
                          input count_t pst, input trg_t msk);
    cfg_aut = aut;
    cfg_con = con;
    cfg_pre = pre;
    cfg_pst = pst;
    cfg_trg = msk;
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic capture_auto_continuous();
    time_t t_stp;
    int    gap;
    set_mode(1'b1, 1'b1, '0, '0, '0);
    pulse_acq();
    for (int k = 0; k < 40; k++) begin
      send_beat(sample_t'($random(seed)), 1'b0);
      gap = $unsigned($random(seed)) % 3;
      idle(gap);
    end
    idle(2);
    pulse_stp(t_stp);
    idle(3);
    check_count("auto_cont sts_pst", count_t'(40), sts_pst);
    check_addr("auto_cont sts_wpt", addr_t'(40), sts_wpt);
    check_time("auto_cont cts_stp", t_stp, cts_stp);
    check_state("auto_cont");
    for (int k = 0; k < 40; k++) begin
      read_check("auto_cont readback", addr_t'(k), exp_mem[addr_t'(k)], 1'b0);
    end
  endtask

  task automatic count_pre_post();
    sample_t d;
    sample_t last;
    time_t   t;
    int      base;
    set_mode(1'b0, 1'b0, count_t'(5), count_t'(7), 4'b0001);
    pulse_acq();
    base = n_trg;
    // enabled source held high while the pre beats go by
    ctl_trg = 4'b0001;
    repeat (5) send_beat(sample_t'($random(seed)), 1'b0);
    ctl_trg = '0;
    if (n_trg != base) report_failure("pre_post: irq_trg before the fifth beat");
    fire_trigger("pre_post", 4'b0001, 1'b1, t);
    check_count("pre_post sts_pre at trigger", count_t'(5), sts_pre);
    base = n_stp;
    // two beats past the stop get dropped
    for (int k = 0; k < 9; k++) begin
      d = sample_t'($random(seed));
      send_beat(d, 1'b0);
      if (k == 5 && n_stp != base) report_failure("pre_post: irq_stp before post beat 7");
      if (k == 6) begin
        last = d;
        if (n_stp != base + 1) report_failure("pre_post: no irq_stp on post beat 7");
      end
    end
    idle(3);
    check_count("pre_post sts_pre", count_t'(5), sts_pre);
    check_count("pre_post sts_pst", count_t'(7), sts_pst);
    check_bit("pre_post sts_acq", 1'b0, sts_acq);
    check_addr("pre_post sts_wpt", addr_t'(12), sts_wpt);
    check_addr("pre_post sts_end", addr_t'(11), sts_end);
    check_state("pre_post");
    read_check("pre_post last beat", addr_t'(11), last, 1'b0);
  endtask

  task automatic mask_trigger_sources();
    time_t t;
    time_t t_stp;
    set_mode(1'b0, 1'b1, count_t'(4), '0, 4'b0010);
    pulse_acq();
    repeat (2) send_beat(sample_t'($random(seed)), 1'b0);
    // masked source then enabled source before the arm
    fire_trigger("mask masked", 4'b0001, 1'b0, t);
    fire_trigger("mask unarmed", 4'b0010, 1'b0, t);
    check_bit("mask sts_trg before arm", 1'b0, sts_trg);
    repeat (2) send_beat(sample_t'($random(seed)), 1'b0);
    idle(1);
    // armed now, the mask alone has to hold off source 0
    fire_trigger("mask armed masked", 4'b0001, 1'b0, t);
    check_bit("mask sts_trg after masked pulse", 1'b0, sts_trg);
    fire_trigger("mask armed", 4'b0010, 1'b1, t);
    check_bit("mask sts_trg", 1'b1, sts_trg);
    check_time("mask cts_trg", t, cts_trg);
    pulse_stp(t_stp);
    idle(2);
    check_state("mask");
  endtask

  task automatic stop_on_stream_end();
    sample_t d;
    set_mode(1'b1, 1'b1, '0, '0, '0);
    pulse_acq();
    repeat (6) send_beat(sample_t'($random(seed)), 1'b0);
    d = sample_t'($random(seed));
    send_beat(d, 1'b1);
    // beats after the end marker
    repeat (3) send_beat(sample_t'($random(seed)), 1'b0);
    idle(3);
    check_bit("stream_end sts_acq", 1'b0, sts_acq);
    check_addr("stream_end sts_end", addr_t'(6), sts_end);
    check_addr("stream_end sts_wpt", addr_t'(7), sts_wpt);
    check_state("stream_end");
    read_check("stream_end lst beat", addr_t'(6), d, 1'b0);
  endtask

  task automatic stream_with_host_reads();
    time_t t_stp;
    int    i;
    set_mode(1'b1, 1'b1, '0, '0, '0);
    pulse_acq();
    strm_done = 1'b0;
    fork
      begin
        repeat (60) send_beat(sample_t'($random(seed)), 1'b0);
        strm_done = 1'b1;
      end
      begin
        i = 0;
        // stay behind the writer so every read hits committed data
        while (!strm_done) begin
          if (int'(m_ptr) >= i + 3) begin
            read_check("contention live", addr_t'(i), exp_mem[addr_t'(i)], i == 4);
            i++;
          end else begin
            @(posedge sti);
            #1;
          end
        end
      end
    join
    idle(2);
    pulse_stp(t_stp);
    idle(3);
    check_count("contention sts_pst", count_t'(60), sts_pst);
    check_addr("contention sts_wpt", addr_t'(60), sts_wpt);
    check_state("contention");
    for (int k = 0; k < 60; k++) begin
      read_check("contention readback", addr_t'(k), exp_mem[addr_t'(k)], 1'b0);
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    seed      = 47;
    cts       = '0;
    ctl_rst   = 1'b1;
    src_vld   = 1'b0;
    src_dat   = '0;
    src_lst   = 1'b0;
    cfg_trg   = '0;
    cfg_con   = 1'b0;
    cfg_aut   = 1'b0;
    cfg_pre   = '0;
    cfg_pst   = '0;
    ctl_acq   = 1'b0;
    ctl_trg   = '0;
    ctl_stp   = 1'b0;
    rd_req    = 1'b0;
    rd_adr    = '0;
    strm_done = 1'b0;
    repeat (8) @(posedge sti);
    #1;
    ctl_rst = 1'b0;
    idle(2);
    check_state("after reset");
    check_bit("after reset rd_bsy", 1'b0, rd_bsy);
    capture_auto_continuous();
    count_pre_post();
    mask_trigger_sources();
    stop_on_stream_end();
    stream_with_host_reads();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- include/acq_config.svh
// sizes shared by the acquisition design and its testbench
// pulled in through acq_pkg, which builds its types from these
`ifndef ACQ_CONFIG_SVH
`define ACQ_CONFIG_SVH

//////////////////////////////
// stream and time
//////////////////////////////

// sample width
`define ACQ_DW 16
// time stamp width
`define ACQ_TW 32

//////////////////////////////
// control and storage
//////////////////////////////

// pre and post trigger counter width
`define ACQ_CW 16
// number of trigger sources
`define ACQ_TN 4
// buffer address width, 256 words
`define ACQ_AW 8

`endif

//--- run_sim.sh
#!/bin/sh
# build the acquisition testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  --top-module acq_tb -f acq_top.f -o acq_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/acq_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1

//--- verilog/acq_buffer.sv
// single-port sample memory shared by writer and reader
// round-robin grant, the port served last loses the next tie
`timescale 1ns/1ps

module acq_buffer import acq_pkg::*; (
  input logic sti,
  input logic ctl_rst,
  // writer port
  acq_mem_if.arbiter wr,
  // reader port
  acq_mem_if.arbiter rd
);

  localparam int unsigned DEPTH = 2**$bits(addr_t);

  // last grant went to the writer
  logic    lst_wr;
  // selected request
  logic    sel_we;
  addr_t   sel_adr;
  sample_t sel_wdt;
  // read data register
  sample_t rdt_q;
  sample_t mem [DEPTH];

  //////////////////////////////
  // arbitration
  //////////////////////////////

  // writer wins unless it was served last and reader waits
  assign wr.gnt = wr.req & (~rd.req | ~lst_wr);
  assign rd.gnt = rd.req & ~wr.gnt;

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      lst_wr <= 1'b0;
    end else if (wr.gnt) begin
      lst_wr <= 1'b1;
    end else if (rd.gnt) begin
      lst_wr <= 1'b0;
    end
  end

  // granted port drives the memory
  assign sel_we  = wr.gnt ? wr.we  : rd.we;
  assign sel_adr = wr.gnt ? wr.adr : rd.adr;
  assign sel_wdt = wr.gnt ? wr.wdt : rd.wdt;

  //////////////////////////////
  // memory
  //////////////////////////////

  always_ff @(posedge sti) begin
    if (wr.gnt | rd.gnt) begin
      if (sel_we) begin
        mem[sel_adr] <= sel_wdt;
      end else begin
        rdt_q <= mem[sel_adr];
      end
    end
  end

  // same registered data to both ports
  assign wr.rdt = rdt_q;
  assign rd.rdt = rdt_q;

endmodule

//--- verilog/acq_mem_if.sv
// request port into the shared sample buffer
// grant comes back in the same cycle, read data one cycle later
`timescale 1ns/1ps

interface acq_mem_if import acq_pkg::*;;

  // request side
  logic    req;
  logic    we;
  addr_t   adr;
  sample_t wdt;
  // arbiter side
  logic    gnt;
  sample_t rdt;

  // requester holds req and fields until gnt
  modport requester (
    output req, we, adr, wdt,
    input  gnt, rdt
  );

  // arbiter grants and returns read data
  modport arbiter (
    input  req, we, adr, wdt,
    output gnt, rdt
  );

endinterface

//--- verilog/acq_pkg.sv
// shared data types for the acquisition path
// import by wildcard in every module and interface that uses them
package acq_pkg;

  `include "acq_config.svh"

  //////////////////////////////
  // stream payload and time
  //////////////////////////////

  // one sample from the stream
  typedef logic [`ACQ_DW-1:0] sample_t;

  // free running time stamp
  typedef logic [`ACQ_TW-1:0] time_t;

  //////////////////////////////
  // control and addressing
  //////////////////////////////

  // pre or post trigger sample count
  typedef logic [`ACQ_CW-1:0] count_t;

  // one bit per trigger source
  typedef logic [`ACQ_TN-1:0] trg_t;

  // sample buffer word address
  typedef logic [`ACQ_AW-1:0] addr_t;

endpackage

//--- verilog/acq_reader.sv
// host read port into the sample buffer
// pulse rd_req while rd_bsy is low, data returns with the rd_vld pulse
`timescale 1ns/1ps

module acq_reader import acq_pkg::*; (
  input  logic    sti,
  input  logic    ctl_rst,
  // host side
  input  logic    rd_req,
  input  addr_t   rd_adr,
  output logic    rd_vld,
  output sample_t rd_dat,
  output logic    rd_bsy,
  // buffer port
  acq_mem_if.requester mem
);

  // new read taken this cycle
  logic  tak;
  // request still waiting for a grant
  logic  wat;
  // data arrives from the buffer
  logic  pnd;
  addr_t adr_q;

  assign tak = rd_req & ~rd_bsy;

  // first try in the request cycle, then retry from the register
  assign mem.req = tak | wat;
  assign mem.we  = 1'b0;
  assign mem.adr = wat ? adr_q : rd_adr;
  assign mem.wdt = '0;

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      rd_bsy <= 1'b0;
      wat    <= 1'b0;
      pnd    <= 1'b0;
    end else begin
      // grant now, data on rdt next cycle
      pnd <= mem.req & mem.gnt;
      if (tak) begin
        rd_bsy <= 1'b1;
        wat    <= ~mem.gnt;
      end else if (wat & mem.gnt) begin
        wat    <= 1'b0;
      end
      // done once data is handed out
      if (pnd) begin
        rd_bsy <= 1'b0;
      end
    end
  end

  // address kept for retries
  always_ff @(posedge sti) begin
    if (tak) begin
      adr_q <= rd_adr;
    end
  end

  assign rd_vld = pnd;
  assign rd_dat = mem.rdt;

endmodule

//--- verilog/acq_stream_if.sv
// sample stream with valid/ready handshake
// a beat moves on a clock edge with vld and rdy both high
`timescale 1ns/1ps

interface acq_stream_if import acq_pkg::*;;

  // handshake
  logic    vld;
  logic    rdy;
  // payload
  sample_t dat;
  // end of trace marker
  logic    lst;

  // producer side, holds a beat until taken
  modport source (
    output vld,
    output dat,
    output lst,
    input  rdy
  );

  // consumer side, rdy may follow vld
  modport sink (
    input  vld,
    input  dat,
    input  lst,
    output rdy
  );

endinterface

//--- verilog/acq_top.sv
// trace acquisition subsystem top level
// stream in through acq_trigger, stored by acq_writer, host reads via acq_reader
`timescale 1ns/1ps

module acq_top import acq_pkg::*; (
  input  logic    sti,
  input  logic    ctl_rst,
  input  time_t   cts,
  // sample stream in
  input  logic    src_vld,
  input  sample_t src_dat,
  input  logic    src_lst,
  output logic    src_rdy,
  // configuration
  input  trg_t    cfg_trg,
  input  logic    cfg_con,
  input  logic    cfg_aut,
  input  count_t  cfg_pre,
  input  count_t  cfg_pst,
  // commands
  input  logic    ctl_acq,
  input  trg_t    ctl_trg,
  input  logic    ctl_stp,
  // status
  output count_t  sts_pre,
  output count_t  sts_pst,
  output logic    sts_acq,
  output logic    sts_trg,
  output time_t   cts_acq,
  output time_t   cts_trg,
  output time_t   cts_stp,
  output logic    irq_trg,
  output logic    irq_stp,
  output addr_t   sts_wpt,
  output addr_t   sts_end,
  // host read
  input  logic    rd_req,
  input  addr_t   rd_adr,
  output logic    rd_vld,
  output sample_t rd_dat,
  output logic    rd_bsy
);

  // acquired stream and the two buffer ports
  acq_stream_if stm_acq ();
  acq_mem_if    mem_wr ();
  acq_mem_if    mem_rd ();

  acq_trigger u_trigger (
    .sti     (sti),
    .ctl_rst (ctl_rst),
    .cts     (cts),
    .cfg_trg (cfg_trg),
    .cfg_con (cfg_con),
    .cfg_aut (cfg_aut),
    .cfg_pre (cfg_pre),
    .cfg_pst (cfg_pst),
    .ctl_acq (ctl_acq),
    .ctl_trg (ctl_trg),
    .ctl_stp (ctl_stp),
    .src_vld (src_vld),
    .src_dat (src_dat),
    .src_lst (src_lst),
    .src_rdy (src_rdy),
    .sto     (stm_acq.source),
    .sts_pre (sts_pre),
    .sts_pst (sts_pst),
    .sts_acq (sts_acq),
    .sts_trg (sts_trg),
    .cts_acq (cts_acq),
    .cts_trg (cts_trg),
    .cts_stp (cts_stp),
    .irq_trg (irq_trg),
    .irq_stp (irq_stp)
  );

  acq_writer u_writer (
    .sti     (sti),
    .ctl_rst (ctl_rst),
    .ctl_acq (ctl_acq),
    .sti_s   (stm_acq.sink),
    .mem     (mem_wr.requester),
    .sts_wpt (sts_wpt),
    .sts_end (sts_end)
  );

  acq_reader u_reader (
    .sti     (sti),
    .ctl_rst (ctl_rst),
    .rd_req  (rd_req),
    .rd_adr  (rd_adr),
    .rd_vld  (rd_vld),
    .rd_dat  (rd_dat),
    .rd_bsy  (rd_bsy),
    .mem     (mem_rd.requester)
  );

  acq_buffer u_buffer (
    .sti     (sti),
    .ctl_rst (ctl_rst),
    .wr      (mem_wr.arbiter),
    .rd      (mem_rd.arbiter)
  );

endmodule

//--- verilog/acq_trigger.sv
// acquisition control on the incoming sample stream
// start, arm, trigger and stop with time stamps and pre/post counters
// beats accepted while capturing pass to sto one cycle later
`timescale 1ns/1ps

module acq_trigger import acq_pkg::*; (
  input  logic   sti,
  input  logic   ctl_rst,
  // current time
  input  time_t  cts,
  // mode
  input  trg_t   cfg_trg,
  input  logic   cfg_con,
  input  logic   cfg_aut,
  input  count_t cfg_pre,
  input  count_t cfg_pst,
  // commands
  input  logic   ctl_acq,
  input  trg_t   ctl_trg,
  input  logic   ctl_stp,
  // input stream
  input  logic   src_vld,
  input  sample_t src_dat,
  input  logic   src_lst,
  output logic   src_rdy,
  // output stream
  acq_stream_if.source sto,
  // status
  output count_t sts_pre,
  output count_t sts_pst,
  output logic   sts_acq,
  output logic   sts_trg,
  output time_t  cts_acq,
  output time_t  cts_trg,
  output time_t  cts_stp,
  // events
  output logic   irq_trg,
  output logic   irq_stp
);

  //////////////////////////////
  // local signals
  //////////////////////////////

  // trigger armed
  logic   ena_pre;
  // beat taken from the input
  logic   xfr;
  // beat taken while capturing
  logic   acc;
  // trigger fires now
  logic   trg;
  // this beat counts as triggered
  logic   trg_now;
  // capture stops now
  logic   stp;
  logic   end_pre;
  logic   end_pst;
  count_t nxt_pre;
  count_t nxt_pst;

  //////////////////////////////
  // event conditions
  //////////////////////////////

  // output register empty or being drained
  assign src_rdy = ~sto.vld | sto.rdy;
  assign xfr     = src_vld & src_rdy;
  assign acc     = sts_acq & xfr;

  assign nxt_pre = sts_pre + 1'b1;
  assign nxt_pst = sts_pst + 1'b1;

  // masked source, only once armed and not yet triggered
  assign trg     = |(ctl_trg & cfg_trg) & sts_acq & ena_pre & ~sts_trg;
  assign trg_now = sts_trg | trg;

  // pre count reaches cfg_pre on an untriggered beat
  assign end_pre = acc & ~trg_now & (nxt_pre == cfg_pre);
  // post count reaches cfg_pst on a triggered beat
  assign end_pst = acc & trg_now & (nxt_pst == cfg_pst);

  // command, post count or stream end
  assign stp = sts_acq & (ctl_stp | (end_pst & ~cfg_con) | (xfr & src_lst));

  assign irq_trg = trg;
  assign irq_stp = stp;

  //////////////////////////////
  // state, stamps, counters
  //////////////////////////////

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      ena_pre <= 1'b0;
      sts_pre <= '0;
      sts_pst <= '0;
      sts_acq <= 1'b0;
      sts_trg <= 1'b0;
      cts_acq <= '0;
      cts_trg <= '0;
      cts_stp <= '0;
    end else begin
      // stop wins over a start in the same cycle
      if (stp) begin
        sts_acq <= 1'b0;
        cts_stp <= cts;
      end else if (ctl_acq) begin
        sts_acq <= 1'b1;
        cts_acq <= cts;
        // automatic mode starts already triggered
        sts_trg <= cfg_aut;
        ena_pre <= ~|cfg_pre;
        sts_pre <= '0;
        sts_pst <= '0;
      end
      // arm after the pre count
      if (end_pre) begin
        ena_pre <= 1'b1;
      end
      if (trg) begin
        sts_trg <= 1'b1;
        cts_trg <= cts;
      end
      // split accepted beats into pre and post
      if (acc) begin
        if (trg_now) begin
          sts_pst <= nxt_pst;
        end else begin
          sts_pre <= nxt_pre;
        end
      end
    end
  end

  //////////////////////////////
  // output stage
  //////////////////////////////

  // valid holds while the sink stalls
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      sto.vld <= 1'b0;
    end else if (src_rdy) begin
      sto.vld <= sts_acq & src_vld;
    end
  end

  // payload, the stopping beat carries lst
  always_ff @(posedge sti) begin
    if (acc) begin
      sto.dat <= src_dat;
      sto.lst <= src_lst | stp;
    end
  end

endmodule

//--- verilog/acq_writer.sv
// stores the acquired stream in the circular sample buffer
// one write request per offered beat, the grant takes the beat
`timescale 1ns/1ps

module acq_writer import acq_pkg::*; (
  input  logic  sti,
  input  logic  ctl_rst,
  input  logic  ctl_acq,
  // acquired stream
  acq_stream_if.sink   sti_s,
  // buffer port
  acq_mem_if.requester mem,
  // write pointer and trace end
  output addr_t sts_wpt,
  output addr_t sts_end
);

  // beat written this cycle
  logic wen;

  //////////////////////////////
  // buffer request
  //////////////////////////////

  // request straight from the stream, held by its source
  assign mem.req   = sti_s.vld;
  assign mem.we    = 1'b1;
  assign mem.adr   = sts_wpt;
  assign mem.wdt   = sti_s.dat;

  // beat taken only once the write is granted
  assign sti_s.rdy = mem.gnt;
  assign wen       = sti_s.vld & mem.gnt;

  //////////////////////////////
  // pointer and end marker
  //////////////////////////////

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      sts_wpt <= '0;
      sts_end <= '0;
    end else if (ctl_acq) begin
      // new trace from address zero
      sts_wpt <= '0;
      sts_end <= '0;
    end else if (wen) begin
      // wraps at the buffer depth
      sts_wpt <= sts_wpt + 1'b1;
      // remember where the trace ends
      if (sti_s.lst) begin
        sts_end <= sts_wpt;
      end
    end
  end

endmodule
